//--- tb/div_trace.txt
# columns, all hex: op (0 udiv, 1 div, 2 urem, 3 rem) dividend divisor expected
# expected follows the rv32m rules, including divide by zero and signed overflow
0 00000064 00000007 0000000e
0 ffffffff 00000001 ffffffff
0 00000005 0000000a 00000000
0 12345678 00001000 00012345
0 ffffffff 80000000 00000001
0 deadbeef 0000ffff 0000deae
0 00000000 00000003 00000000
0 80000000 00000003 2aaaaaaa
2 00000064 00000007 00000002
2 00000005 0000000a 00000005
2 deadbeef 0000ffff 00009d9d
2 80000000 00000003 00000002
2 ffffffff 80000000 7fffffff
2 12345679 00001000 00000679
1 00000007 00000002 00000003
1 00000007 fffffffe fffffffd
1 fffffff9 00000002 fffffffd
1 fffffff9 fffffffe 00000003
1 ffffff9c 00000007 fffffff2
1 00000064 ffffffff ffffff9c
1 80000000 00000002 c0000000
1 00000001 80000000 00000000
3 00000007 00000002 00000001
3 00000007 fffffffe 00000001
3 fffffff9 00000002 ffffffff
3 fffffff9 fffffffe ffffffff
3 ffffff9c 00000007 fffffffe
3 80000000 00000003 fffffffe
3 00000005 00000008 00000005
0 12345678 00000000 ffffffff
1 87654321 00000000 ffffffff
2 12345678 00000000 12345678
3 87654321 00000000 87654321
1 80000000 ffffffff 80000000
3 80000000 ffffffff 00000000

//--- filelist.f
source/div_pkg.sv
source/div_operand_prep.sv
source/div_serial_core.sv
source/div_result_buf.sv
source/div_unit_top.sv
tb/tb_div_unit.sv

//--- run_sim.sh
#!/bin/sh
# build the divide unit testbench with verilator and run it
# exit status is zero only when the run reports a pass

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_div_unit -f filelist.f -o sim_div_unit || exit 1

out=$(./obj_dir/sim_div_unit)
echo "$out"
echo "$out" | grep -qx "sim passed" && exit 0 || exit 1

//--- tb/tb_div_unit.sv
`timescale 1ns/1ps
`default_nettype none

/*
 * divide unit testbench
 * replays a trace of ops against the expected results, with random output stalls
 */
module tb_div_unit;

  import div_pkg::*;

  // cycles any single wait may take
  localparam int max_wait = 2000;

  logic                 Clk_CI;
  logic                 Rst_RBI;
  logic                 in_valid;
  div_op_u              op;
  logic [div_width-1:0] op_a;
  logic [div_width-1:0] op_b;
  logic                 out_ready;
  logic                 in_ready;
  logic                 out_valid;
  logic [div_width-1:0] out_result;

  // trace columns
  logic [1:0]           tr_op[$];
  logic [div_width-1:0] tr_a[$];
  logic [div_width-1:0] tr_b[$];
  logic [div_width-1:0] tr_exp[$];
  // trace index of each accepted op, issue order
  int                   pend_q[$];

  int     n_errors;
  int     n_timeouts;
  bit     abort;
  integer seed = 32'hd882_4a12;

  initial Clk_CI = 1'b0;
  always #50 Clk_CI = ~Clk_CI;

  div_unit_top u_dut (
    .Clk_CI     (Clk_CI),
    .Rst_RBI    (Rst_RBI),
    .in_valid   (in_valid),
    .op         (op),
    .op_a       (op_a),
    .op_b       (op_b),
    .out_ready  (out_ready),
    .in_ready   (in_ready),
    .out_valid  (out_valid),
    .out_result (out_result)
  );

  //////////////////////////////////////////////////
  // trace file
  //////////////////////////////////////////////////

  task automatic load_trace();
    int                   fd;
    int                   rc;
    string                line;
    logic [1:0]           o;
    logic [div_width-1:0] a;
    logic [div_width-1:0] b;
    logic [div_width-1:0] e;
    fd = $fopen("tb/div_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file tb/div_trace.txt");
      n_errors++;
      return;
    end
    while (!$feof(fd)) begin
      rc = $fgets(line, fd);
      // skip comment and blank lines
      if (rc > 0 && line[0] != "#") begin
        if ($sscanf(line, "%h %h %h %h", o, a, b, e) == 4) begin
          tr_op.push_back(o);
          tr_a.push_back(a);
          tr_b.push_back(b);
          tr_exp.push_back(e);
        end
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////
  // driver and checker
  //////////////////////////////////////////////////

  // called just after a rising edge, returns just after the accept edge
  task automatic send_op(input int idx);
    int waited;
    waited   = 0;
    in_valid = 1'b1;
    op.code  = tr_op[idx];
    op_a     = tr_a[idx];
    op_b     = tr_b[idx];
    @(negedge Clk_CI);
    while (!in_ready && !abort) begin
      if (waited == max_wait) begin
        $display("timeout: op %0d of the trace was never accepted", idx);
        n_timeouts++;
        abort = 1'b1;
      end else begin
        waited++;
        @(negedge Clk_CI);
      end
    end
    if (!abort) begin
      // in_ready seen here, so the next edge accepts
      pend_q.push_back(idx);
      @(posedge Clk_CI);
      #1;
      in_valid = 1'b0;
    end
  endtask

  // sampled on falling edges, between drive and capture
  task automatic check_outputs(input int n_ops);
    int                   n_done;
    int                   waited;
    int                   idx;
    bit                   held;
    logic [div_width-1:0] held_val;
    n_done   = 0;
    waited   = 0;
    held     = 1'b0;
    held_val = '0;
    while (n_done < n_ops && !abort) begin
      @(negedge Clk_CI);
      // stalled result must not move
      if (held) begin
        assert (out_valid && out_result == held_val) else begin
          n_errors++;
          $display("Fail %0t: stalled result moved, valid %b got %h exp %h",
                   $time, out_valid, out_result, held_val);
        end
      end
      held = 1'b0;
      if (out_valid && out_ready) begin
        waited = 0;
        n_done++;
        assert (pend_q.size() > 0) else begin
          n_errors++;
          $display("a result came out with no operation in flight");
        end
        if (pend_q.size() > 0) begin
          idx = pend_q.pop_front();
          assert (out_result == tr_exp[idx]) else begin
            n_errors++;
            $display("Fail %0t: op %0d a %h b %h got %h exp %h",
                     $time, tr_op[idx], tr_a[idx], tr_b[idx], out_result, tr_exp[idx]);
          end
        end
      end else begin
        held     = out_valid;
        held_val = out_result;
        if (waited == max_wait) begin
          $display("timeout: no result after %0d cycles", max_wait);
          n_timeouts++;
          abort = 1'b1;
        end else begin
          waited++;
        end
      end
    end
  endtask

  // out_ready in random stretches of up to 8 cycles
  initial begin
    int r;
    int stretch;
    stretch = 0;
    @(posedge Rst_RBI);
    forever begin
      @(posedge Clk_CI);
      #1;
      if (stretch == 0) begin
        r         = $random(seed);
        out_ready = r[0];
        stretch   = int'(r[3:1]);
      end else begin
        stretch--;
      end
    end
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    int n_ops;
    Rst_RBI    = 1'b0;
    in_valid   = 1'b0;
    op         = '0;
    op_a       = '0;
    op_b       = '0;
    out_ready  = 1'b0;
    n_errors   = 0;
    n_timeouts = 0;
    abort      = 1'b0;
    load_trace();
    n_ops = tr_op.size();
    assert (n_ops > 0) else begin
      n_errors++;
      $display("the trace holds no operations");
      abort = 1'b1;
    end
    repeat (5) @(posedge Clk_CI);
    #1;
    Rst_RBI = 1'b1;
    // idle state right after reset
    @(negedge Clk_CI);
    assert (!out_valid && in_ready) else begin
      n_errors++;
      $display("Fail %0t: after reset out_valid %b in_ready %b", $time, out_valid, in_ready);
    end
    @(posedge Clk_CI);
    #1;
    fork
      begin
        for (int i = 0; i < n_ops && !abort; i++) begin
          send_op(i);
        end
      end
      check_outputs(n_ops);
    join
    // no extra result after the last one
    if (!abort) begin
      repeat (20) begin
        @(negedge Clk_CI);
        assert (!out_valid) else begin
          n_errors++;
          $display("Fail %0t: extra result %h after the trace", $time, out_result);
        end
      end
    end
    $display("errors %0d timeouts %0d", n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/div_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

/*
 * divide unit top
 * operand preparation, serial divider and one-entry result buffer
 */
module div_unit_top (
  input  logic                           Clk_CI,
  input  logic                           Rst_RBI,
  input  logic                           in_valid,
  input  div_pkg::div_op_u               op,
  input  logic [div_pkg::div_width-1:0]  op_a,
  input  logic [div_pkg::div_width-1:0]  op_b,
  input  logic                           out_ready,
  output logic                           in_ready,
  output logic                           out_valid,
  output logic [div_pkg::div_width-1:0]  out_result
);

  import div_pkg::*;

  div_operands_t        prep;
  logic                 core_valid;
  logic                 core_ready;
  logic [div_width-1:0] core_result;

  // input side, combinational
  div_operand_prep u_prep (
    .op   (op),
    .op_a (op_a),
    .op_b (op_b),
    .prep (prep)
  );

  // in_valid doubles as the start strobe
  div_serial_core u_core (
    .Clk_CI      (Clk_CI),
    .Rst_RBI     (Rst_RBI),
    .start       (in_valid),
    .prep        (prep),
    .core_ready  (core_ready),
    .in_ready    (in_ready),
    .core_valid  (core_valid),
    .core_result (core_result)
  );

  div_result_buf u_buf (
    .Clk_CI      (Clk_CI),
    .Rst_RBI     (Rst_RBI),
    .core_valid  (core_valid),
    .core_result (core_result),
    .out_ready   (out_ready),
    .core_ready  (core_ready),
    .out_valid   (out_valid),
    .out_result  (out_result)
  );

endmodule

`default_nettype wire

//--- source/div_result_buf.sv
`timescale 1ns/1ps
`default_nettype none

/*
 * divide result buffer
 * one entry between the divider and the consumer, so the divider
 * can start the next op while a result waits
 */
module div_result_buf (
  input  logic                           Clk_CI,
  input  logic                           Rst_RBI,
  input  logic                           core_valid,
  input  logic [div_pkg::div_width-1:0]  core_result,
  input  logic                           out_ready,
  output logic                           core_ready,
  output logic                           out_valid,
  output logic [div_pkg::div_width-1:0]  out_result
);

  import div_pkg::*;

  logic                 full_q;
  logic                 fill;
  logic [div_width-1:0] data_q;

  //////////////////////////////////////////////////
  // entry control
  //////////////////////////////////////////////////

  // free slot, or the slot drains in this cycle
  assign core_ready = ~full_q | out_ready;
  assign fill       = core_valid & core_ready;

  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      full_q <= 1'b0;
    end else if (fill) begin
      // fill wins over a drain in the same cycle
      full_q <= 1'b1;
    end else if (out_ready) begin
      full_q <= 1'b0;
    end
  end

  // payload
  always_ff @(posedge Clk_CI) begin
    if (fill) begin
      data_q <= core_result;
    end
  end

  assign out_valid  = full_q;
  assign out_result = data_q;

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // stalled result stays put until taken
  a_out_stable: assert property (
    @(posedge Clk_CI) disable iff (!Rst_RBI)
    (out_valid && !out_ready) |=> out_valid && $stable(out_result)
  ) else $error("result changed under back-pressure");

endmodule

`default_nettype wire

//--- source/div_serial_core.sv
`timescale 1ns/1ps
`default_nettype none

/*
 * serial restoring divider
 * one quotient bit per cycle, variable cycle count from the operand shift,
 * sign handling for the rv32m div, divu, rem and remu ops
 */
module div_serial_core (
  input  logic                           Clk_CI,
  input  logic                           Rst_RBI,
  input  logic                           start,
  input  div_pkg::div_operands_t         prep,
  input  logic                           core_ready,
  output logic                           in_ready,
  output logic                           core_valid,
  output logic [div_pkg::div_width-1:0]  core_result
);

  import div_pkg::*;

  enum logic [1:0] {st_idle, st_divide, st_finish} state_d, state_q;

  logic                     load;
  logic                     a_neg;
  logic                     sub_en;
  logic                     cnt_zero;
  logic [div_cnt_width-1:0] cnt_q;

  // datapath registers
  logic [div_width-1:0]     rem_q;
  logic [div_width-1:0]     dvs_q;
  logic [div_width-1:0]     quot_q;
  logic [div_width-1:0]     quot_rev;
  logic [div_width-1:0]     out_mux;

  // flags latched on load
  logic                     rem_sel_q;
  logic                     comp_inv_q;
  logic                     res_inv_q;
  logic                     dvs_zero_q;

  //////////////////////////////////////////////////
  // handshake and FSM
  //////////////////////////////////////////////////

  assign in_ready   = (state_q == st_idle);
  assign core_valid = (state_q == st_finish);
  assign load       = start & in_ready;
  assign cnt_zero   = (cnt_q == '0);

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle:   if (load)       state_d = st_divide;
      // last divide cycle runs with the counter at zero
      st_divide: if (cnt_zero)   state_d = st_finish;
      st_finish: if (core_ready) state_d = st_idle;
      default:                   state_d = st_idle;
    endcase
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      state_q <= st_idle;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (load) begin
        cnt_q <= prep.shift;
      end else if (state_q == st_divide && !cnt_zero) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////

  // operand signs differ on a signed op
  assign a_neg = prep.op.f.is_signed & (prep.dividend[div_width-1] ^ prep.divisor_sign);

  // compare inverted when the divisor is negative
  // an empty remainder never subtracts unless dividing by zero
  assign sub_en = ((rem_q == dvs_q) | ((rem_q > dvs_q) ^ comp_inv_q)) &
                  ((|rem_q) | dvs_zero_q);

  always_ff @(posedge Clk_CI) begin
    if (load) begin
      // remainder starts in the sign domain of the divisor
      rem_q      <= a_neg ? -prep.dividend : prep.dividend;
      // align divisor top bit with the dividend
      dvs_q      <= prep.divisor << prep.shift;
      quot_q     <= '0;
      rem_sel_q  <= prep.op.f.is_rem;
      comp_inv_q <= prep.divisor_sign;
      // quotient on divide by zero stays all ones
      res_inv_q  <= (~prep.divisor_zero | prep.op.f.is_rem) & a_neg;
      dvs_zero_q <= prep.divisor_zero;
    end else if (state_q == st_divide) begin
      if (sub_en) begin
        rem_q <= rem_q - dvs_q;
      end
      // arithmetic shift for a negative divisor
      dvs_q  <= {comp_inv_q, dvs_q[div_width-1:1]};
      // quotient bits enter at the top with the msb first
      quot_q <= {sub_en, quot_q[div_width-1:1]};
    end
  end

  //////////////////////////////////////////////////
  // result
  //////////////////////////////////////////////////

  // undo the bit reversal of the quotient
  always_comb begin
    for (int i = 0; i < div_width; i++) begin
      quot_rev[i] = quot_q[div_width-1-i];
    end
  end

  assign out_mux = rem_sel_q ? rem_q : quot_rev;

  // negation on differing signs puts the remainder in the sign of the dividend
  assign core_result = res_inv_q ? -out_mux : out_mux;

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // an accepted op holds both handshakes low for at least one cycle
  a_accept_busy: assert property (
    @(posedge Clk_CI) disable iff (!Rst_RBI)
    load |=> !in_ready && !core_valid
  ) else $error("handshake active right after accept");

  // a wrap below zero would leave the counter above div_width
  a_cnt_no_wrap: assert property (
    @(posedge Clk_CI) disable iff (!Rst_RBI)
    cnt_q <= div_cnt_width'(div_width)
  ) else $error("divide counter wrapped");

endmodule

`default_nettype wire

//--- source/div_operand_prep.sv
`timescale 1ns/1ps
`default_nettype none

/*
 * divide operand preparation
 * decodes the op word, gates the divisor sign, flags a zero divisor
 * and sizes the iteration count from the leading sign bits of the divisor
 */
module div_operand_prep (
  input  div_pkg::div_op_u               op,
  input  logic [div_pkg::div_width-1:0]  op_a,
  input  logic [div_pkg::div_width-1:0]  op_b,
  output div_pkg::div_operands_t         prep
);

  import div_pkg::*;

  logic                     b_sign;
  logic                     b_zero;
  logic [div_width-1:0]     scan_vec;
  logic [div_width-1:0]     diff_vec;
  logic [div_cnt_width-1:0] lead_cnt;

  //////////////////////////////////////////////////
  // divisor flags
  //////////////////////////////////////////////////

  // sign only matters for div and rem
  assign b_sign = op.f.is_signed & op_b[div_width-1];
  assign b_zero = (op_b == '0);

  //////////////////////////////////////////////////
  // leading sign count
  //////////////////////////////////////////////////

  // negative divisor keeps one sign bit after alignment,
  // so its top bit is dropped before counting
  assign scan_vec = b_sign ? {op_b[div_width-2:0], 1'b0} : op_b;

  // bits equal to the sign turn into zeros
  assign diff_vec = scan_vec ^ {div_width{b_sign}};

  // leading zero count of diff_vec
  // highest set bit wins, all zero gives the full width
  always_comb begin
    lead_cnt = div_cnt_width'(div_width);
    for (int i = 0; i < div_width; i++) begin
      if (diff_vec[i]) begin
        lead_cnt = div_cnt_width'(div_width - 1 - i);
      end
    end
  end

  //////////////////////////////////////////////////
  // bundle for the core
  //////////////////////////////////////////////////

  assign prep.op           = op;
  assign prep.dividend     = op_a;
  assign prep.divisor      = op_b;
  assign prep.divisor_sign = b_sign;
  assign prep.divisor_zero = b_zero;
  // aligned divisor gives shift + 1 quotient bits
  assign prep.shift        = lead_cnt;

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // shift stays in counter range and only a zero divisor
  // reaches the full width, checked on every divisor change
  a_shift_range: assert property (
    @(op_b)
    (prep.shift <= div_cnt_width'(div_width)) &&
    (prep.divisor_zero == (prep.shift == div_cnt_width'(div_width)))
  ) else $error("divisor shift out of range");

endmodule

`default_nettype wire

//--- source/div_pkg.sv
`default_nettype none

/*
 * divide unit package
 * width constants, the op word union and the prepared operand bundle
 * shared by the input side and the serial divider
 */
package div_pkg;

  // operand and result width
  localparam int unsigned div_width     = 32;
  // counter holds 0 .. div_width
  localparam int unsigned div_cnt_width = $clog2(div_width + 1);

  // op word, raw code or two flags
  // 0 udiv, 1 div, 2 urem, 3 rem
  typedef union packed {
    logic [1:0] code;
    struct packed {
      logic is_rem;
      logic is_signed;
    } f;
  } div_op_u;

  // one prepared operation, input side to core
  typedef struct packed {
    div_op_u                  op;
    logic [div_width-1:0]     dividend;
    logic [div_width-1:0]     divisor;
    // zero for unsigned ops
    logic                     divisor_sign;
    logic                     divisor_zero;
    // quotient bits minus one, full width on zero divisor
    logic [div_cnt_width-1:0] shift;
  } div_operands_t;

endpackage

`default_nettype wire
